// File: hw/conv_store_pkg.sv
package conv_store_pkg;

  //////////////////////////////////////////////////////////////////////
  // array geometry
  //////////////////////////////////////////////////////////////////////

  localparam int sa_row_num    = 4;
  // output rows per tile, max cur_poy
  localparam int sa_column_num = 3;
  localparam int fifo_num      = sa_row_num * sa_column_num;
  localparam int fifo_depth    = 16;

  // channels per fifo row in mode 0, doubled in mode 1
  localparam int row_num_in_sa      = 16;
  localparam int row_num_in_sa_2pow = 4;

  //////////////////////////////////////////////////////////////////////
  // ddr layout
  //////////////////////////////////////////////////////////////////////

  // two channels per ddr word
  localparam int ofs_in_row_2pow    = 1;
  localparam int pixels_in_row_2pow = 5;
  localparam int ddr_cmd_word_num   = 32;

  localparam int conv_word_width = 256;
  localparam int ddr_word_width  = 512;

  typedef logic [ddr_word_width-1:0]  ddr_word_t;
  typedef logic [conv_word_width-1:0] conv_word_t;
  typedef logic [31:0]                ddr_adr_t;
  typedef logic [15:0]                tile_dim_t;
  typedef logic [15:0]                store_len_t;
  typedef logic [fifo_num-1:0]        fifo_sel_t;
  typedef logic [3:0]                 fifo_idx_t;
  // 0 is 8x8, 1 is packed pairs
  typedef logic [3:0]                 store_mode_t;
  typedef logic [3:0]                 shift_t;

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_data,
    st_fin
  } store_state_t;

endpackage

// File: hw/conv_out_fifo_bank.sv
`timescale 1ns/1ps

module conv_out_fifo_bank (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wr,
  input  conv_store_pkg::fifo_idx_t  wr_idx,
  input  conv_store_pkg::ddr_word_t  wr_data,
  input  conv_store_pkg::fifo_sel_t  rd_sel,
  output conv_store_pkg::ddr_word_t  rd_data
);

  conv_store_pkg::ddr_word_t mem [conv_store_pkg::fifo_num][conv_store_pkg::fifo_depth];

  // depth is a power of two, pointers wrap on their own
  logic [$clog2(conv_store_pkg::fifo_depth)-1:0] wr_ptr [conv_store_pkg::fifo_num];
  logic [$clog2(conv_store_pkg::fifo_depth)-1:0] rd_ptr [conv_store_pkg::fifo_num];

  conv_store_pkg::ddr_word_t head;

  // head of the popped fifo, rd_sel is one-hot
  always_comb begin
    head = '0;
    for (int i = 0; i < conv_store_pkg::fifo_num; i++) begin
      if (rd_sel[i]) begin
        head = mem[i][rd_ptr[i]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < conv_store_pkg::fifo_num; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
      end
    end else begin
      if (wr) begin
        wr_ptr[wr_idx] <= wr_ptr[wr_idx] + 1'b1;
      end
      for (int i = 0; i < conv_store_pkg::fifo_num; i++) begin
        if (rd_sel[i]) begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
      end
    end
  end

  // storage and read register
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_idx][wr_ptr[wr_idx]] <= wr_data;
    end
    if (|rd_sel) begin
      rd_data <= head;
    end
  end

endmodule

// File: hw/store_loop_counter.sv
`timescale 1ns/1ps

module store_loop_counter (
  input  logic                         clk,
  input  logic                         reset,
  input  conv_store_pkg::store_mode_t  mode,
  input  conv_store_pkg::tile_dim_t    cur_pof,
  input  conv_store_pkg::tile_dim_t    cur_poy,
  input  logic                         load_burst,
  input  conv_store_pkg::store_len_t   burst_len,
  input  logic                         in_data,
  input  logic                         ddr_wt_data_ready,
  output conv_store_pkg::fifo_sel_t    rd_sel,
  output logic                         rd_en,
  output logic                         rd_pair_second,
  output logic                         rd_burst_last
);

  logic mode0;
  logic mode1;

  // channel within fifo row, fifo row, output row
  conv_store_pkg::tile_dim_t ch_cnt;
  conv_store_pkg::tile_dim_t row_cnt;
  conv_store_pkg::tile_dim_t oy_cnt;

  conv_store_pkg::tile_dim_t ch_step;
  conv_store_pkg::tile_dim_t ch_per_row;
  conv_store_pkg::tile_dim_t ch_abs;
  conv_store_pkg::tile_dim_t ch_next;
  logic                      row_done;
  logic                      oy_done;
  logic                      pair_second_pending;

  // pops done in the current burst
  conv_store_pkg::store_len_t pop_cnt;
  conv_store_pkg::store_len_t pop_target;

  conv_store_pkg::fifo_idx_t fifo_idx;

  assign mode0 = (mode == 4'd0);
  assign mode1 = (mode == 4'd1);

  //////////////////////////////////////////////////////////////////////
  // read order position
  //////////////////////////////////////////////////////////////////////

  assign ch_step    = mode1 ? 16'd2 : 16'd1;
  assign ch_per_row = conv_store_pkg::tile_dim_t'(conv_store_pkg::row_num_in_sa) << mode1;
  assign ch_abs     = (row_cnt << (conv_store_pkg::row_num_in_sa_2pow + mode1)) + ch_cnt;
  assign ch_next    = ch_cnt + ch_step;

  // last channel of the output row
  assign oy_done  = (ch_abs + ch_step >= cur_pof);
  assign row_done = (ch_next == ch_per_row);

  // odd channel in mode 0 is the second half of a ddr word
  assign pair_second_pending = mode0 && ch_cnt[0];

  //////////////////////////////////////////////////////////////////////
  // pop control
  //////////////////////////////////////////////////////////////////////

  assign pop_target = mode0 ? (burst_len << 1) : burst_len;

  assign rd_en = in_data && (pop_cnt < pop_target) &&
                 (ddr_wt_data_ready || pair_second_pending);

  assign rd_pair_second = rd_en && pair_second_pending;
  assign rd_burst_last  = rd_en && (pop_cnt + 16'd1 == pop_target);

  assign fifo_idx = conv_store_pkg::fifo_idx_t'(oy_cnt * conv_store_pkg::sa_row_num + row_cnt);
  assign rd_sel   = rd_en ? (conv_store_pkg::fifo_sel_t'(1) << fifo_idx) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      ch_cnt  <= '0;
      row_cnt <= '0;
      oy_cnt  <= '0;
    end else if (rd_en) begin
      if (oy_done) begin
        ch_cnt  <= '0;
        row_cnt <= '0;
        oy_cnt  <= (oy_cnt + 16'd1 == cur_poy) ? '0 : oy_cnt + 16'd1;
      end else if (row_done) begin
        ch_cnt  <= '0;
        row_cnt <= row_cnt + 16'd1;
      end else begin
        ch_cnt <= ch_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || load_burst) begin
      pop_cnt <= '0;
    end else if (rd_en) begin
      pop_cnt <= pop_cnt + 16'd1;
    end
  end

endmodule

// File: hw/store_cmd_gen.sv
`timescale 1ns/1ps

module store_cmd_gen (
  input  logic                        clk,
  input  logic                        reset,
  input  conv_store_pkg::ddr_adr_t    output_ddr_layer_base_adr,
  input  conv_store_pkg::shift_t      of_in_2pow,
  input  conv_store_pkg::shift_t      ox_in_2pow,
  input  conv_store_pkg::tile_dim_t   cur_ox_start,
  input  conv_store_pkg::tile_dim_t   cur_oy_start,
  input  conv_store_pkg::tile_dim_t   cur_of_start,
  input  conv_store_pkg::tile_dim_t   cur_pof,
  input  conv_store_pkg::tile_dim_t   cur_poy,
  input  logic                        cmd_fire,
  output conv_store_pkg::ddr_adr_t    store_ddr_base_adr,
  output conv_store_pkg::store_len_t  store_ddr_length,
  output logic                        last_cmd,
  output conv_store_pkg::store_len_t  burst_len
);

  // first channel of the chunk and output row of the next command
  conv_store_pkg::tile_dim_t  chunk_ch;
  conv_store_pkg::tile_dim_t  oy_cnt;
  conv_store_pkg::tile_dim_t  half_left;
  conv_store_pkg::store_len_t cur_len;
  logic                       row_last;
  logic                       tile_last;

  logic [5:0]               row_shift;
  conv_store_pkg::ddr_adr_t row_term;
  conv_store_pkg::ddr_adr_t x_term;
  conv_store_pkg::ddr_adr_t ch_term;

  //////////////////////////////////////////////////////////////////////
  // command length
  //////////////////////////////////////////////////////////////////////

  assign half_left = (cur_pof - chunk_ch) >> conv_store_pkg::ofs_in_row_2pow;
  assign cur_len   = (half_left > conv_store_pkg::ddr_cmd_word_num) ?
                     conv_store_pkg::store_len_t'(conv_store_pkg::ddr_cmd_word_num) : half_left;

  assign row_last  = (chunk_ch + (cur_len << conv_store_pkg::ofs_in_row_2pow) >= cur_pof);
  assign tile_last = row_last && (oy_cnt + 16'd1 == cur_poy);

  assign store_ddr_length = cur_len;

  //////////////////////////////////////////////////////////////////////
  // command address
  //////////////////////////////////////////////////////////////////////

  // ddr words per output row, in log2
  assign row_shift = 6'(of_in_2pow) + 6'(ox_in_2pow) -
                     6'(conv_store_pkg::ofs_in_row_2pow + conv_store_pkg::pixels_in_row_2pow);

  assign row_term = (conv_store_pkg::ddr_adr_t'(cur_oy_start) +
                     conv_store_pkg::ddr_adr_t'(oy_cnt)) << row_shift;
  assign x_term   = (conv_store_pkg::ddr_adr_t'(cur_ox_start) <<
                     (of_in_2pow - conv_store_pkg::ofs_in_row_2pow)) >>
                    conv_store_pkg::pixels_in_row_2pow;
  assign ch_term  = (conv_store_pkg::ddr_adr_t'(cur_of_start) +
                     conv_store_pkg::ddr_adr_t'(chunk_ch)) >> conv_store_pkg::ofs_in_row_2pow;

  assign store_ddr_base_adr = output_ddr_layer_base_adr + row_term + x_term + ch_term;

  always_ff @(posedge clk) begin
    if (reset) begin
      chunk_ch  <= '0;
      oy_cnt    <= '0;
      burst_len <= '0;
      last_cmd  <= 1'b0;
    end else if (cmd_fire) begin
      burst_len <= cur_len;
      last_cmd  <= tile_last;
      if (row_last) begin
        chunk_ch <= '0;
        oy_cnt   <= tile_last ? '0 : oy_cnt + 16'd1;
      end else begin
        chunk_ch <= chunk_ch + (cur_len << conv_store_pkg::ofs_in_row_2pow);
      end
    end
  end

endmodule

// File: hw/store_word_packer.sv
`timescale 1ns/1ps

module store_word_packer (
  input  logic                         clk,
  input  logic                         reset,
  input  conv_store_pkg::store_mode_t  mode,
  input  conv_store_pkg::ddr_word_t    rd_data,
  input  logic                         rd_en,
  input  logic                         rd_pair_second,
  input  logic                         rd_burst_last,
  output conv_store_pkg::ddr_word_t    conv_out_ddr_data,
  output logic                         valid_conv_out_ddr_data,
  output logic                         burst_end
);

  // pop flags, aligned with fifo read data
  logic rd_en_q;
  logic pair_second_q;
  logic burst_last_q;

  // first channel of a mode 0 pair
  conv_store_pkg::conv_word_t low_q;
  conv_store_pkg::conv_word_t cur_low;

  logic mode0;
  logic mode1;

  assign mode0   = (mode == 4'd0);
  assign mode1   = (mode == 4'd1);
  assign cur_low = rd_data[conv_store_pkg::conv_word_width-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en_q       <= 1'b0;
      pair_second_q <= 1'b0;
      burst_last_q  <= 1'b0;
    end else begin
      rd_en_q       <= rd_en;
      pair_second_q <= rd_pair_second;
      burst_last_q  <= rd_burst_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_q && mode0 && !pair_second_q) begin
      low_q <= cur_low;
    end
  end

  // a word leaves on every mode 1 pop or on the second half of a pair
  assign valid_conv_out_ddr_data = rd_en_q && (mode1 || (mode0 && pair_second_q));
  assign burst_end               = valid_conv_out_ddr_data && burst_last_q;

  assign conv_out_ddr_data = !valid_conv_out_ddr_data ? '0 :
                             mode0 ? {cur_low, low_q} : rd_data;

endmodule

// File: hw/store_ctrl_fsm.sv
`timescale 1ns/1ps

module store_ctrl_fsm (
  input  logic clk,
  input  logic reset,
  input  logic conv_store_start,
  input  logic ddr_cmd_ready,
  input  logic burst_end,
  input  logic last_cmd,
  output logic valid_store_ddr_cmd,
  output logic in_data,
  output logic conv_store_fin
);

  conv_store_pkg::store_state_t state;
  conv_store_pkg::store_state_t state_nxt;

  //////////////////////////////////////////////////////////////////////
  // tile sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      conv_store_pkg::st_idle: begin
        if (conv_store_start) begin
          state_nxt = conv_store_pkg::st_cmd;
        end
      end
      // wait for the ddr side to take the command
      conv_store_pkg::st_cmd: begin
        if (ddr_cmd_ready) begin
          state_nxt = conv_store_pkg::st_data;
        end
      end
      conv_store_pkg::st_data: begin
        if (burst_end) begin
          state_nxt = last_cmd ? conv_store_pkg::st_fin : conv_store_pkg::st_cmd;
        end
      end
      conv_store_pkg::st_fin: begin
        state_nxt = conv_store_pkg::st_idle;
      end
      default: begin
        state_nxt = conv_store_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_store_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // command fire also loads the counters for the burst
  assign valid_store_ddr_cmd = (state == conv_store_pkg::st_cmd) && ddr_cmd_ready;
  assign in_data             = (state == conv_store_pkg::st_data);
  assign conv_store_fin      = (state == conv_store_pkg::st_fin);

endmodule

// File: hw/conv_store_top.sv
`timescale 1ns/1ps

module conv_store_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         conv_store_start,
  input  conv_store_pkg::store_mode_t  mode,
  input  conv_store_pkg::ddr_adr_t     output_ddr_layer_base_adr,
  input  conv_store_pkg::shift_t       of_in_2pow,
  input  conv_store_pkg::shift_t       ox_in_2pow,
  input  conv_store_pkg::tile_dim_t    cur_ox_start,
  input  conv_store_pkg::tile_dim_t    cur_oy_start,
  input  conv_store_pkg::tile_dim_t    cur_of_start,
  input  conv_store_pkg::tile_dim_t    cur_pof,
  input  conv_store_pkg::tile_dim_t    cur_poy,
  input  logic                         ddr_cmd_ready,
  input  logic                         ddr_wt_data_ready,
  input  logic                         fifo_wr,
  input  conv_store_pkg::fifo_idx_t    fifo_wr_idx,
  input  conv_store_pkg::ddr_word_t    fifo_wr_data,
  output conv_store_pkg::ddr_adr_t     store_ddr_base_adr,
  output conv_store_pkg::store_len_t   store_ddr_length,
  output logic                         valid_store_ddr_cmd,
  output conv_store_pkg::ddr_word_t    conv_out_ddr_data,
  output logic                         valid_conv_out_ddr_data,
  output logic                         conv_store_fin
);

  conv_store_pkg::fifo_sel_t  rd_sel;
  conv_store_pkg::ddr_word_t  rd_data;
  logic                       rd_en;
  logic                       rd_pair_second;
  logic                       rd_burst_last;
  conv_store_pkg::store_len_t burst_len;
  logic                       last_cmd;
  logic                       burst_end;
  logic                       in_data;

  conv_out_fifo_bank fifo_bank_i (
    .clk     (clk),
    .reset   (reset),
    .wr      (fifo_wr),
    .wr_idx  (fifo_wr_idx),
    .wr_data (fifo_wr_data),
    .rd_sel  (rd_sel),
    .rd_data (rd_data)
  );

  store_loop_counter loop_counter_i (
    .clk               (clk),
    .reset             (reset),
    .mode              (mode),
    .cur_pof           (cur_pof),
    .cur_poy           (cur_poy),
    .load_burst        (valid_store_ddr_cmd),
    .burst_len         (burst_len),
    .in_data           (in_data),
    .ddr_wt_data_ready (ddr_wt_data_ready),
    .rd_sel            (rd_sel),
    .rd_en             (rd_en),
    .rd_pair_second    (rd_pair_second),
    .rd_burst_last     (rd_burst_last)
  );

  store_cmd_gen cmd_gen_i (
    .clk                       (clk),
    .reset                     (reset),
    .output_ddr_layer_base_adr (output_ddr_layer_base_adr),
    .of_in_2pow                (of_in_2pow),
    .ox_in_2pow                (ox_in_2pow),
    .cur_ox_start              (cur_ox_start),
    .cur_oy_start              (cur_oy_start),
    .cur_of_start              (cur_of_start),
    .cur_pof                   (cur_pof),
    .cur_poy                   (cur_poy),
    .cmd_fire                  (valid_store_ddr_cmd),
    .store_ddr_base_adr        (store_ddr_base_adr),
    .store_ddr_length          (store_ddr_length),
    .last_cmd                  (last_cmd),
    .burst_len                 (burst_len)
  );

  store_word_packer word_packer_i (
    .clk                     (clk),
    .reset                   (reset),
    .mode                    (mode),
    .rd_data                 (rd_data),
    .rd_en                   (rd_en),
    .rd_pair_second          (rd_pair_second),
    .rd_burst_last           (rd_burst_last),
    .conv_out_ddr_data       (conv_out_ddr_data),
    .valid_conv_out_ddr_data (valid_conv_out_ddr_data),
    .burst_end               (burst_end)
  );

  store_ctrl_fsm ctrl_fsm_i (
    .clk                 (clk),
    .reset               (reset),
    .conv_store_start    (conv_store_start),
    .ddr_cmd_ready       (ddr_cmd_ready),
    .burst_end           (burst_end),
    .last_cmd            (last_cmd),
    .valid_store_ddr_cmd (valid_store_ddr_cmd),
    .in_data             (in_data),
    .conv_store_fin      (conv_store_fin)
  );

endmodule

// File: dv/conv_store_tb.sv
`timescale 1ns/1ps

module conv_store_tb;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        conv_store_start;
  conv_store_pkg::store_mode_t mode;
  conv_store_pkg::ddr_adr_t    output_ddr_layer_base_adr;
  conv_store_pkg::shift_t      of_in_2pow;
  conv_store_pkg::shift_t      ox_in_2pow;
  conv_store_pkg::tile_dim_t   cur_ox_start;
  conv_store_pkg::tile_dim_t   cur_oy_start;
  conv_store_pkg::tile_dim_t   cur_of_start;
  conv_store_pkg::tile_dim_t   cur_pof;
  conv_store_pkg::tile_dim_t   cur_poy;
  logic                        ddr_cmd_ready;
  logic                        ddr_wt_data_ready;
  logic                        fifo_wr;
  conv_store_pkg::fifo_idx_t   fifo_wr_idx;
  conv_store_pkg::ddr_word_t   fifo_wr_data;
  conv_store_pkg::ddr_adr_t    store_ddr_base_adr;
  conv_store_pkg::store_len_t  store_ddr_length;
  logic                        valid_store_ddr_cmd;
  conv_store_pkg::ddr_word_t   conv_out_ddr_data;
  logic                        valid_conv_out_ddr_data;
  logic                        conv_store_fin;

  string test_name = "reset";
  logic  rand_ready = 1'b0;
  int    start_cnt = 0;

  // expected streams filled by the main process and walked by the checker
  conv_store_pkg::ddr_adr_t   exp_adr[$];
  conv_store_pkg::store_len_t exp_len[$];
  conv_store_pkg::ddr_word_t  exp_data[$];
  int                         pop_fifo[$];
  int                         rd_ord[conv_store_pkg::fifo_num] = '{default: 0};
  int                         wr_ord[conv_store_pkg::fifo_num] = '{default: 0};

  int cmd_idx = 0;
  int data_idx = 0;
  int fin_cnt = 0;
  int cyc = 0;
  int last_data_cyc = -10;

  // data ready seen one and two cycles back
  logic rdy_d1 = 1'b0;
  logic rdy_d2 = 1'b0;

  conv_store_top dut_i (.*);

  always #50 clk = ~clk;

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // fifo entry tagged with fifo number and write ordinal
  // upper half differs from the lower half
  function automatic conv_store_pkg::ddr_word_t fill_word(int fidx, int ord);
    logic [31:0] tag;
    tag = {8'hc0, 8'(fidx), 16'(ord)};
    return {{8{tag ^ 32'h5a5a_0000}}, {8{tag}}};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void build_expected();
    int                         per_row;
    int                         step;
    int                         len;
    int                         fidx;
    int                         row_sh;
    conv_store_pkg::ddr_word_t  w;
    conv_store_pkg::conv_word_t first_low;
    logic                       pending;
    per_row = (mode == 4'd1) ? 2 * conv_store_pkg::row_num_in_sa : conv_store_pkg::row_num_in_sa;
    step = (mode == 4'd1) ? 2 : 1;
    row_sh = int'(of_in_2pow) + int'(ox_in_2pow) - 6;
    pending = 1'b0;
    first_low = '0;
    pop_fifo.delete();
    for (int oy = 0; oy < int'(cur_poy); oy++) begin
      // commands in chunks of 64 channels
      for (int c = 0; c < int'(cur_pof); c += 2 * conv_store_pkg::ddr_cmd_word_num) begin
        len = (int'(cur_pof) - c) / 2;
        if (len > conv_store_pkg::ddr_cmd_word_num) begin
          len = conv_store_pkg::ddr_cmd_word_num;
        end
        exp_len.push_back(conv_store_pkg::store_len_t'(len));
        exp_adr.push_back(output_ddr_layer_base_adr +
                          ((32'(cur_oy_start) + 32'(oy)) << row_sh) +
                          ((32'(cur_ox_start) << (int'(of_in_2pow) - 1)) >> 5) +
                          ((32'(cur_of_start) + 32'(c)) >> 1));
      end
      // pops in read order through each fifo row in turn
      for (int c = 0; c < int'(cur_pof); c += step) begin
        fidx = oy * conv_store_pkg::sa_row_num + c / per_row;
        pop_fifo.push_back(fidx);
        w = fill_word(fidx, rd_ord[fidx]);
        rd_ord[fidx]++;
        if (mode == 4'd1) begin
          exp_data.push_back(w);
        end else if (pending) begin
          exp_data.push_back({w[255:0], first_low});
          pending = 1'b0;
        end else begin
          first_low = w[255:0];
          pending = 1'b1;
        end
      end
    end
  endfunction

  task automatic fill_fifos();
    foreach (pop_fifo[i]) begin
      @(negedge clk);
      fifo_wr      = 1'b1;
      fifo_wr_idx  = conv_store_pkg::fifo_idx_t'(pop_fifo[i]);
      fifo_wr_data = fill_word(pop_fifo[i], wr_ord[pop_fifo[i]]);
      wr_ord[pop_fifo[i]]++;
    end
    @(negedge clk);
    fifo_wr = 1'b0;
  endtask

  task automatic run_tile(string name, int md, int pof, int poy, logic [31:0] base,
                          int of2, int ox2, int oxs, int oys, int ofs, logic rnd);
    int waited;
    @(negedge clk);
    test_name                 = name;
    rand_ready                = rnd;
    mode                      = conv_store_pkg::store_mode_t'(md);
    cur_pof                   = conv_store_pkg::tile_dim_t'(pof);
    cur_poy                   = conv_store_pkg::tile_dim_t'(poy);
    output_ddr_layer_base_adr = base;
    of_in_2pow                = conv_store_pkg::shift_t'(of2);
    ox_in_2pow                = conv_store_pkg::shift_t'(ox2);
    cur_ox_start              = conv_store_pkg::tile_dim_t'(oxs);
    cur_oy_start              = conv_store_pkg::tile_dim_t'(oys);
    cur_of_start              = conv_store_pkg::tile_dim_t'(ofs);
    build_expected();
    fill_fifos();
    conv_store_start = 1'b1;
    start_cnt++;
    @(negedge clk);
    conv_store_start = 1'b0;
    waited = 0;
    while (fin_cnt != start_cnt) begin
      @(negedge clk);
      waited++;
      if (waited > 5000) begin
        fail_run($sformatf("%s: timeout waiting for conv_store_fin", name));
      end
    end
    // a few idle cycles so a stray fin or word gets caught
    repeat (4) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // ddr ready levels
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(13683));
    ddr_cmd_ready     = 1'b1;
    ddr_wt_data_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (rand_ready) begin
        ddr_cmd_ready     = ($urandom % 3) != 0;
        ddr_wt_data_ready = ($urandom % 4) != 0;
      end else begin
        ddr_cmd_ready     = 1'b1;
        ddr_wt_data_ready = 1'b1;
      end
    end
  end

  // compares every command, word and fin against the reference
  always @(posedge clk) begin
    cyc++;
    if (!reset) begin
      if (valid_store_ddr_cmd) begin
        assert (ddr_cmd_ready)
          else fail_run($sformatf("%s: DDR command issued while ddr_cmd_ready was low",
                                  test_name));
        assert (cmd_idx < exp_adr.size())
          else fail_run($sformatf("%s: DDR command issued with none expected", test_name));
        assert (store_ddr_base_adr == exp_adr[cmd_idx])
          else fail_run($sformatf("Error %s: command address expected %h actual %h",
                                  test_name, exp_adr[cmd_idx], store_ddr_base_adr));
        assert (store_ddr_length == exp_len[cmd_idx])
          else fail_run($sformatf("Error %s: command length expected %0d actual %0d",
                                  test_name, exp_len[cmd_idx], store_ddr_length));
        cmd_idx++;
      end
      if (valid_conv_out_ddr_data) begin
        assert (data_idx < exp_data.size())
          else fail_run($sformatf("%s: DDR data word sent with none expected", test_name));
        // the pop that needed ready came one cycle earlier in mode 1 and two in mode 0
        assert ((mode == 4'd1) ? rdy_d1 : rdy_d2)
          else fail_run($sformatf("%s: data word %0d sent without a ready from the DDR side",
                                  test_name, data_idx));
        assert (conv_out_ddr_data == exp_data[data_idx])
          else fail_run($sformatf("Error %s: data word %0d expected %h actual %h",
                                  test_name, data_idx, exp_data[data_idx], conv_out_ddr_data));
        data_idx++;
        last_data_cyc = cyc;
      end else begin
        assert (conv_out_ddr_data == '0)
          else fail_run($sformatf("Error %s: idle data expected 0 actual %h",
                                  test_name, conv_out_ddr_data));
      end
      if (conv_store_fin) begin
        assert (fin_cnt < start_cnt)
          else fail_run($sformatf("%s: conv_store_fin pulsed with no tile running", test_name));
        assert (cmd_idx == exp_adr.size() && data_idx == exp_data.size())
          else fail_run($sformatf("%s: conv_store_fin came before all commands and words",
                                  test_name));
        assert (cyc == last_data_cyc + 1)
          else fail_run($sformatf("%s: conv_store_fin not one cycle after the last word",
                                  test_name));
        fin_cnt++;
      end
    end
    rdy_d2 = rdy_d1;
    rdy_d1 = ddr_wt_data_ready;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset                     = 1'b1;
    conv_store_start          = 1'b0;
    mode                      = '0;
    output_ddr_layer_base_adr = '0;
    of_in_2pow                = 4'd5;
    ox_in_2pow                = 4'd5;
    cur_ox_start              = '0;
    cur_oy_start              = '0;
    cur_of_start              = '0;
    cur_pof                   = '0;
    cur_poy                   = 16'd1;
    fifo_wr                   = 1'b0;
    fifo_wr_idx               = '0;
    fifo_wr_data              = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // no start, so nothing may come out
    test_name = "idle_after_reset";
    repeat (20) @(negedge clk);

    run_tile("mode1_single_row", 1, 32, 1, 32'h0000_0100, 5, 5, 0, 0, 0, 1'b0);
    run_tile("mode0_two_rows", 0, 64, 2, 32'h0001_0000, 6, 5, 0, 1, 0, 1'b0);
    run_tile("mode1_split_rows", 1, 128, 3, 32'h1000_0000, 7, 6, 64, 2, 64, 1'b0);
    run_tile("mode0_random_ready", 0, 64, 3, 32'h0001_0000, 6, 5, 0, 1, 0, 1'b1);
    run_tile("mode1_random_ready", 1, 128, 3, 32'h1000_0000, 7, 6, 64, 2, 64, 1'b1);
    run_tile("mode0_partial_row", 0, 36, 1, 32'h0000_2000, 6, 6, 32, 5, 128, 1'b1);

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: flist.f
hw/conv_store_pkg.sv
hw/conv_out_fifo_bank.sv
hw/store_loop_counter.sv
hw/store_cmd_gen.sv
hw/store_word_packer.sv
hw/store_ctrl_fsm.sv
hw/conv_store_top.sv
dv/conv_store_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the conv store testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal --top-module conv_store_tb -f flist.f -o conv_store_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/conv_store_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^Done: no errors$" "$log" || exit 1
exit 0
